//--- chess_pkg.sv
package chess_pkg;

  // one square of the board with the colour in bit 3
  typedef logic [3:0] piece_t;

  // file or rank index
  typedef logic [2:0] coord_t;

  // one of eight step directions for the path walk
  typedef logic [2:0] dir_t;

  localparam logic [2:0] kind_empty  = 3'd0;
  localparam logic [2:0] kind_pawn   = 3'd1;
  localparam logic [2:0] kind_knight = 3'd2;
  localparam logic [2:0] kind_bishop = 3'd3;
  localparam logic [2:0] kind_rook   = 3'd4;
  localparam logic [2:0] kind_queen  = 3'd5;
  localparam logic [2:0] kind_king   = 3'd6;

  localparam piece_t piece_empty = 4'h0;

  localparam int board_squares = 64;

  // pawn home ranks, white moving toward higher ranks
  localparam coord_t white_pawn_rank = 3'd1;
  localparam coord_t black_pawn_rank = 3'd6;

  // direction codes with north toward higher ranks
  localparam dir_t dir_n  = 3'd0;
  localparam dir_t dir_ne = 3'd1;
  localparam dir_t dir_e  = 3'd2;
  localparam dir_t dir_se = 3'd3;
  localparam dir_t dir_s  = 3'd4;
  localparam dir_t dir_sw = 3'd5;
  localparam dir_t dir_w  = 3'd6;
  localparam dir_t dir_nw = 3'd7;

  typedef struct packed {
    logic [21:0] unused;
    coord_t      x;
    coord_t      y;
    piece_t      piece;
  } board_cmd_s;

  typedef struct packed {
    logic [19:0] unused;
    coord_t      from_x;
    coord_t      from_y;
    coord_t      to_x;
    coord_t      to_y;
  } move_cmd_s;

  // one write word whose meaning depends on the register offset
  typedef union packed {
    board_cmd_s board;
    move_cmd_s  move;
  } host_word_u;

  localparam logic [3:0] reg_board_off  = 4'h0;
  localparam logic [3:0] reg_move_off   = 4'h4;
  localparam logic [3:0] reg_status_off = 4'h8;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- board_ram.sv
`timescale 1ns/1ps

module board_ram (
  input  logic              clk,
  input  logic              reset,
  input  logic              we,
  input  chess_pkg::coord_t wr_x,
  input  chess_pkg::coord_t wr_y,
  input  chess_pkg::piece_t wr_piece,
  input  chess_pkg::coord_t rd_x,
  input  chess_pkg::coord_t rd_y,
  output chess_pkg::piece_t rd_piece
);
  import chess_pkg::*;

  piece_t     mem [board_squares];
  logic [5:0] clr_addr;
  logic       clearing;

  // clear sweep of one square per cycle after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      clearing <= 1'b1;
      clr_addr <= 6'd0;
    end else if (clearing) begin
      clr_addr <= clr_addr + 6'd1;
      if (clr_addr == 6'(board_squares - 1)) begin
        clearing <= 1'b0;
      end
    end
  end

  // squares indexed as rank * 8 + file
  always_ff @(posedge clk) begin
    if (clearing) begin
      mem[clr_addr] <= piece_empty;
    end else if (we) begin
      mem[{wr_y, wr_x}] <= wr_piece;
    end
    rd_piece <= mem[{rd_y, rd_x}];
  end

endmodule

//--- step_geometry.sv
`timescale 1ns/1ps

module step_geometry (
  input  chess_pkg::piece_t src_piece,
  input  chess_pkg::piece_t dst_piece,
  input  chess_pkg::coord_t from_x,
  input  chess_pkg::coord_t from_y,
  input  chess_pkg::coord_t to_x,
  input  chess_pkg::coord_t to_y,
  output logic              geom_ok,
  output logic              needs_path,
  output chess_pkg::dir_t   dir,
  output logic [2:0]        path_len
);
  import chess_pkg::*;

  logic [2:0] adx, ady, span, src_kind;
  logic       east, west, north, south;
  logic       src_black, dst_empty, dst_own, dst_enemy;
  logic       null_move, straight, diagonal, forward, pawn_home;
  logic       kind_ok, slide;

  assign east  = to_x > from_x;
  assign west  = to_x < from_x;
  assign north = to_y > from_y;
  assign south = to_y < from_y;

  assign adx  = east ? to_x - from_x : from_x - to_x;
  assign ady  = north ? to_y - from_y : from_y - to_y;
  assign span = (adx > ady) ? adx : ady;

  assign src_kind  = src_piece[2:0];
  assign src_black = src_piece[3];
  assign dst_empty = dst_piece[2:0] == kind_empty;
  assign dst_own   = !dst_empty && (dst_piece[3] == src_black);
  assign dst_enemy = !dst_empty && (dst_piece[3] != src_black);

  assign null_move = (adx == 3'd0) && (ady == 3'd0);
  assign straight  = (adx == 3'd0) != (ady == 3'd0);
  assign diagonal  = (adx == ady) && !null_move;

  // pawn direction and home rank depend on colour
  assign forward   = src_black ? south : north;
  assign pawn_home = from_y == (src_black ? black_pawn_rank : white_pawn_rank);

  always_comb begin
    kind_ok = 1'b0;
    slide   = 1'b0;
    case (src_kind)
      kind_pawn: begin
        if (adx == 3'd0 && ady == 3'd1 && forward && dst_empty) begin
          kind_ok = 1'b1;
        end else if (adx == 3'd0 && ady == 3'd2 && forward && pawn_home && dst_empty) begin
          kind_ok = 1'b1;
          slide   = 1'b1;
        end else if (adx == 3'd1 && ady == 3'd1 && forward && dst_enemy) begin
          kind_ok = 1'b1;
        end
      end
      kind_knight: kind_ok = (adx == 3'd1 && ady == 3'd2) || (adx == 3'd2 && ady == 3'd1);
      kind_bishop: begin
        kind_ok = diagonal;
        slide   = diagonal;
      end
      kind_rook: begin
        kind_ok = straight;
        slide   = straight;
      end
      kind_queen: begin
        kind_ok = straight || diagonal;
        slide   = straight || diagonal;
      end
      kind_king: kind_ok = (adx <= 3'd1) && (ady <= 3'd1);
      default:   kind_ok = 1'b0;
    endcase
  end

  assign geom_ok = (src_kind != kind_empty) && !null_move && !dst_own && kind_ok;

  // only moves longer than one square have intermediate squares
  assign needs_path = slide && (span > 3'd1);
  assign path_len   = span - 3'd1;

  always_comb begin
    case ({north, south, east, west})
      4'b1000: dir = dir_n;
      4'b1010: dir = dir_ne;
      4'b0010: dir = dir_e;
      4'b0110: dir = dir_se;
      4'b0100: dir = dir_s;
      4'b0101: dir = dir_sw;
      4'b0001: dir = dir_w;
      4'b1001: dir = dir_nw;
      default: dir = dir_n;
    endcase
  end

endmodule

//--- path_scanner.sv
`timescale 1ns/1ps

module path_scanner (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  chess_pkg::coord_t from_x,
  input  chess_pkg::coord_t from_y,
  input  chess_pkg::dir_t   dir,
  input  logic [2:0]        path_len,
  input  chess_pkg::piece_t rd_piece,
  output chess_pkg::coord_t scan_x,
  output chess_pkg::coord_t scan_y,
  output logic              done,
  output logic              blocked
);
  import chess_pkg::*;

  coord_t     cur_x, cur_y;
  logic [2:0] cnt;
  logic       active, blocked_q, hit;
  logic       x_up, x_dn, y_up, y_dn;

  always_comb begin
    x_up = (dir == dir_ne) || (dir == dir_e) || (dir == dir_se);
    x_dn = (dir == dir_sw) || (dir == dir_w) || (dir == dir_nw);
    y_up = (dir == dir_nw) || (dir == dir_n) || (dir == dir_ne);
    y_dn = (dir == dir_se) || (dir == dir_s) || (dir == dir_sw);
  end

  // square presented to the board is one step past the last one
  assign scan_x = x_up ? cur_x + 3'd1 : (x_dn ? cur_x - 3'd1 : cur_x);
  assign scan_y = y_up ? cur_y + 3'd1 : (y_dn ? cur_y - 3'd1 : cur_y);

  // board data trails the address by a cycle, so step 0 has nothing to check
  assign hit     = active && (cnt != 3'd0) && (rd_piece[2:0] != kind_empty);
  assign done    = active && (cnt == path_len);
  assign blocked = blocked_q || hit;

  always_ff @(posedge clk) begin
    if (reset) begin
      active    <= 1'b0;
      cnt       <= 3'd0;
      blocked_q <= 1'b0;
    end else if (start) begin
      active    <= 1'b1;
      cnt       <= 3'd0;
      blocked_q <= 1'b0;
    end else if (active) begin
      cnt       <= cnt + 3'd1;
      blocked_q <= blocked;
      if (done) begin
        active <= 1'b0;
      end
    end
  end

  // walk position starts on the source square
  always_ff @(posedge clk) begin
    if (start) begin
      cur_x <= from_x;
      cur_y <= from_y;
    end else if (active) begin
      cur_x <= scan_x;
      cur_y <= scan_y;
    end
  end

endmodule

//--- move_controller.sv
`timescale 1ns/1ps

module move_controller (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  chess_pkg::coord_t from_x,
  input  chess_pkg::coord_t from_y,
  input  chess_pkg::coord_t to_x,
  input  chess_pkg::coord_t to_y,
  input  chess_pkg::piece_t rd_piece,
  input  logic              geom_ok,
  input  logic              needs_path,
  input  chess_pkg::dir_t   dir,
  input  logic [2:0]        path_len,
  input  chess_pkg::coord_t scan_x,
  input  chess_pkg::coord_t scan_y,
  input  logic              scan_done,
  input  logic              blocked,
  output logic              busy,
  output logic              done,
  output logic              legal,
  output chess_pkg::coord_t rd_x,
  output chess_pkg::coord_t rd_y,
  output chess_pkg::piece_t src_piece,
  output chess_pkg::piece_t dst_piece,
  output logic              scan_start,
  output chess_pkg::dir_t   dir_out,
  output logic [2:0]        path_len_out
);

  localparam logic [2:0] st_idle      = 3'd0;
  localparam logic [2:0] st_fetch_src = 3'd1;
  localparam logic [2:0] st_fetch_dst = 3'd2;
  localparam logic [2:0] st_judge     = 3'd3;
  localparam logic [2:0] st_scan      = 3'd4;
  localparam logic [2:0] st_finish    = 3'd5;

  logic [2:0] state, state_nx;

  // finish holds the last verdict until the next request
  assign busy = (state == st_fetch_src) || (state == st_fetch_dst) ||
                (state == st_judge) || (state == st_scan);
  assign done = state == st_finish;

  assign scan_start = (state == st_judge) && geom_ok && needs_path;

  always_comb begin
    state_nx = state;
    case (state)
      st_idle, st_finish: begin
        if (start) begin
          state_nx = st_fetch_src;
        end
      end
      st_fetch_src: state_nx = st_fetch_dst;
      st_fetch_dst: state_nx = st_judge;
      st_judge:     state_nx = scan_start ? st_scan : st_finish;
      st_scan: begin
        if (scan_done) begin
          state_nx = st_finish;
        end
      end
      default: state_nx = st_idle;
    endcase
  end

  // source address goes out while idle so its data lands in fetch source
  always_comb begin
    case (state)
      st_fetch_src: begin
        rd_x = to_x;
        rd_y = to_y;
      end
      st_scan: begin
        rd_x = scan_x;
        rd_y = scan_y;
      end
      default: begin
        rd_x = from_x;
        rd_y = from_y;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      legal <= 1'b0;
    end else begin
      state <= state_nx;
      if ((state == st_idle || state == st_finish) && start) begin
        legal <= 1'b0;
      end else if (state == st_judge && !scan_start) begin
        legal <= geom_ok;
      end else if (state == st_scan && scan_done) begin
        legal <= geom_ok && !blocked;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_fetch_src) begin
      src_piece <= rd_piece;
    end
    if (state == st_fetch_dst) begin
      dst_piece <= rd_piece;
    end
    // walk parameters held for the whole scan
    if (scan_start) begin
      dir_out      <= dir;
      path_len_out <= path_len;
    end
  end

endmodule

//--- axil_regs.sv
`timescale 1ns/1ps

module axil_regs #(
  parameter int axil_addr_w = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [axil_addr_w-1:0] s_awaddr,
  input  logic                   s_awvalid,
  output logic                   s_awready,
  input  logic [31:0]            s_wdata,
  input  logic [3:0]             s_wstrb,
  input  logic                   s_wvalid,
  output logic                   s_wready,
  output logic [1:0]             s_bresp,
  output logic                   s_bvalid,
  input  logic                   s_bready,
  input  logic [axil_addr_w-1:0] s_araddr,
  input  logic                   s_arvalid,
  output logic                   s_arready,
  output logic [31:0]            s_rdata,
  output logic [1:0]             s_rresp,
  output logic                   s_rvalid,
  input  logic                   s_rready,
  output logic                   sq_we,
  output chess_pkg::coord_t      sq_x,
  output chess_pkg::coord_t      sq_y,
  output chess_pkg::piece_t      sq_piece,
  output logic                   start,
  output chess_pkg::coord_t      from_x,
  output chess_pkg::coord_t      from_y,
  output chess_pkg::coord_t      to_x,
  output chess_pkg::coord_t      to_y,
  input  logic                   busy,
  input  logic                   done,
  input  logic                   legal
);
  import chess_pkg::*;

  host_word_u wword;
  coord_t     from_x_q, from_y_q, to_x_q, to_y_q;
  logic       wr_rdy, rd_rdy, wr_fire, rd_fire;
  logic       aw_board, aw_move, cmd_ok, reject;

  assign wword = s_wdata;

  // address and data taken together with one ready pulse per write
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_rdy <= 1'b0;
      rd_rdy <= 1'b0;
    end else begin
      wr_rdy <= !wr_rdy && s_awvalid && s_wvalid && !s_bvalid;
      rd_rdy <= !rd_rdy && s_arvalid && !s_rvalid;
    end
  end

  assign s_awready = wr_rdy;
  assign s_wready  = wr_rdy;
  assign s_arready = rd_rdy;
  assign wr_fire   = wr_rdy && s_awvalid && s_wvalid;
  assign rd_fire   = rd_rdy && s_arvalid;

  assign aw_board = s_awaddr == axil_addr_w'(reg_board_off);
  assign aw_move  = s_awaddr == axil_addr_w'(reg_move_off);
  // command fields sit in the low two bytes
  assign cmd_ok   = &s_wstrb[1:0];
  assign reject   = busy && (aw_board || aw_move);

  assign sq_we    = wr_fire && aw_board && cmd_ok && !busy;
  assign sq_x     = wword.board.x;
  assign sq_y     = wword.board.y;
  assign sq_piece = wword.board.piece;
  assign start    = wr_fire && aw_move && cmd_ok && !busy;

  // move squares pass straight through on the accepting cycle and are held after
  assign from_x = start ? wword.move.from_x : from_x_q;
  assign from_y = start ? wword.move.from_y : from_y_q;
  assign to_x   = start ? wword.move.to_x : to_x_q;
  assign to_y   = start ? wword.move.to_y : to_y_q;

  always_ff @(posedge clk) begin
    if (start) begin
      from_x_q <= wword.move.from_x;
      from_y_q <= wword.move.from_y;
      to_x_q   <= wword.move.to_x;
      to_y_q   <= wword.move.to_y;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s_bvalid <= 1'b0;
      s_bresp  <= resp_okay;
    end else if (wr_fire) begin
      s_bvalid <= 1'b1;
      s_bresp  <= reject ? resp_slverr : resp_okay;
    end else if (s_bready) begin
      s_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s_rvalid <= 1'b0;
      s_rdata  <= 32'd0;
    end else if (rd_fire) begin
      s_rvalid <= 1'b1;
      if (s_araddr == axil_addr_w'(reg_status_off)) begin
        s_rdata <= {29'd0, legal, done, busy};
      end else begin
        s_rdata <= 32'd0;
      end
    end else if (s_rready) begin
      s_rvalid <= 1'b0;
    end
  end

  assign s_rresp = resp_okay;

endmodule

//--- chess_checker_top.sv
`timescale 1ns/1ps

module chess_checker_top #(
  parameter int axil_addr_w = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [axil_addr_w-1:0] s_awaddr,
  input  logic                   s_awvalid,
  output logic                   s_awready,
  input  logic [31:0]            s_wdata,
  input  logic [3:0]             s_wstrb,
  input  logic                   s_wvalid,
  output logic                   s_wready,
  output logic [1:0]             s_bresp,
  output logic                   s_bvalid,
  input  logic                   s_bready,
  input  logic [axil_addr_w-1:0] s_araddr,
  input  logic                   s_arvalid,
  output logic                   s_arready,
  output logic [31:0]            s_rdata,
  output logic [1:0]             s_rresp,
  output logic                   s_rvalid,
  input  logic                   s_rready
);
  import chess_pkg::*;

  logic       sq_we, start, busy, done, legal;
  coord_t     sq_x, sq_y, from_x, from_y, to_x, to_y;
  coord_t     rd_x, rd_y, scan_x, scan_y;
  piece_t     sq_piece, rd_piece, src_piece, dst_piece;
  logic       geom_ok, needs_path, scan_start, scan_done, blocked;
  dir_t       dir, scan_dir;
  logic [2:0] path_len, scan_len;

  axil_regs #(
    .axil_addr_w(axil_addr_w)
  ) i_axil_regs (
    .clk, .reset,
    .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready, .s_araddr, .s_arvalid, .s_arready,
    .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .sq_we, .sq_x, .sq_y, .sq_piece,
    .start, .from_x, .from_y, .to_x, .to_y,
    .busy, .done, .legal
  );

  move_controller i_move_controller (
    .clk, .reset, .start, .from_x, .from_y, .to_x, .to_y, .rd_piece,
    .geom_ok, .needs_path, .dir, .path_len, .scan_x, .scan_y, .scan_done, .blocked,
    .busy, .done, .legal, .rd_x, .rd_y, .src_piece, .dst_piece, .scan_start,
    .dir_out(scan_dir), .path_len_out(scan_len)
  );

  board_ram i_board_ram (
    .clk, .reset, .we(sq_we), .wr_x(sq_x), .wr_y(sq_y), .wr_piece(sq_piece),
    .rd_x, .rd_y, .rd_piece
  );

  step_geometry i_step_geometry (
    .src_piece, .dst_piece, .from_x, .from_y, .to_x, .to_y,
    .geom_ok, .needs_path, .dir, .path_len
  );

  path_scanner i_path_scanner (
    .clk, .reset, .start(scan_start), .from_x, .from_y, .dir(scan_dir),
    .path_len(scan_len), .rd_piece, .scan_x, .scan_y, .done(scan_done), .blocked
  );

endmodule

//--- tb_chess_checker.sv
`timescale 1ns/1ps

module tb_chess_checker;
  import chess_pkg::*;

  localparam int addr_w       = 8;
  localparam int n_moves      = 230;
  localparam int setup_cycles = 4000;
  localparam int max_busy     = 10;
  localparam int max_polls    = 30;

  logic              clk;
  logic              reset;
  logic [addr_w-1:0] s_awaddr, s_araddr;
  logic              s_awvalid, s_awready, s_wvalid, s_wready;
  logic [31:0]       s_wdata, s_rdata;
  logic [3:0]        s_wstrb;
  logic [1:0]        s_bresp, s_rresp;
  logic              s_bvalid, s_bready, s_arvalid, s_arready, s_rvalid, s_rready;

  logic        dut_busy, dut_done;
  int          busy_len;
  int          errors, checks;
  piece_t      model [board_squares];

  chess_checker_top #(
    .axil_addr_w(addr_w)
  ) i_chess_checker_top (
    .clk, .reset,
    .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready, .s_araddr, .s_arvalid, .s_arready,
    .s_rdata, .s_rresp, .s_rvalid, .s_rready
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // controller state seen from outside for the latency checks
  assign dut_busy = i_chess_checker_top.busy;
  assign dut_done = i_chess_checker_top.done;

  always @(posedge clk) begin
    if (reset || !dut_busy) begin
      busy_len <= 0;
    end else begin
      busy_len <= busy_len + 1;
    end
  end

  bresp_after_write: assert property (@(posedge clk) disable iff (reset)
    $rose(s_bvalid) |-> $past(s_awvalid && s_awready && s_wvalid && s_wready))
    else begin
      errors++;
      $display("Fail %0t: write response raised without an accepted write", $time);
    end

  rdata_after_read: assert property (@(posedge clk) disable iff (reset)
    $rose(s_rvalid) |-> $past(s_arvalid && s_arready))
    else begin
      errors++;
      $display("Fail %0t: read data raised without an accepted read", $time);
    end

  busy_bounded: assert property (@(posedge clk) disable iff (reset) busy_len <= max_busy)
    else begin
      errors++;
      $display("Fail %0t: move stayed busy for more than %0d cycles", $time, max_busy);
    end

  done_on_fall: assert property (@(posedge clk) disable iff (reset)
    $fell(dut_busy) |-> dut_done)
    else begin
      errors++;
      $display("Fail %0t: busy fell without done", $time);
    end

  // run limit scales with the number of moves
  initial begin
    repeat (n_moves * 200 + setup_cycles) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic piece_t make_piece(input logic black, input logic [2:0] kind);
    return {black, kind};
  endfunction

  function automatic logic [31:0] board_word(input int x, input int y, input piece_t p);
    host_word_u w;
    w             = '0;
    w.board.x     = coord_t'(x);
    w.board.y     = coord_t'(y);
    w.board.piece = p;
    return w;
  endfunction

  function automatic logic [31:0] move_word(input int fx, input int fy, input int tx,
                                            input int ty);
    host_word_u w;
    w             = '0;
    w.move.from_x = coord_t'(fx);
    w.move.from_y = coord_t'(fy);
    w.move.to_x   = coord_t'(tx);
    w.move.to_y   = coord_t'(ty);
    return w;
  endfunction

  // every square strictly between two aligned squares is empty
  function automatic logic path_clear(input int fx, input int fy, input int tx, input int ty);
    int   sx, sy, n, x, y;
    logic clear;
    sx    = (tx > fx) ? 1 : ((tx < fx) ? -1 : 0);
    sy    = (ty > fy) ? 1 : ((ty < fy) ? -1 : 0);
    n     = ((tx - fx) * sx > (ty - fy) * sy) ? (tx - fx) * sx : (ty - fy) * sy;
    clear = 1'b1;
    x     = fx;
    y     = fy;
    for (int k = 1; k < n; k++) begin
      x = x + sx;
      y = y + sy;
      if (model[y * 8 + x][2:0] != kind_empty) clear = 1'b0;
    end
    return clear;
  endfunction

  function automatic logic ref_legal(input int fx, input int fy, input int tx, input int ty);
    piece_t src, dst;
    int     dx, dy, adx, ady, fwd, home;
    logic   ok, dst_empty;
    src       = model[fy * 8 + fx];
    dst       = model[ty * 8 + tx];
    dx        = tx - fx;
    dy        = ty - fy;
    adx       = (dx < 0) ? -dx : dx;
    ady       = (dy < 0) ? -dy : dy;
    fwd       = src[3] ? -1 : 1;
    home      = src[3] ? 6 : 1;
    dst_empty = dst[2:0] == kind_empty;
    ok        = 1'b0;
    if (src[2:0] == kind_empty || (dx == 0 && dy == 0)) return 1'b0;
    if (!dst_empty && dst[3] == src[3]) return 1'b0;
    case (src[2:0])
      kind_pawn: begin
        if (dx == 0 && dy == fwd && dst_empty) ok = 1'b1;
        if (dx == 0 && dy == 2 * fwd && fy == home && dst_empty &&
            path_clear(fx, fy, tx, ty)) ok = 1'b1;
        if (adx == 1 && dy == fwd && !dst_empty) ok = 1'b1;
      end
      kind_knight: ok = adx * ady == 2;
      kind_bishop: ok = (adx == ady) && path_clear(fx, fy, tx, ty);
      kind_rook:   ok = (dx == 0 || dy == 0) && path_clear(fx, fy, tx, ty);
      kind_queen:  ok = (adx == ady || dx == 0 || dy == 0) && path_clear(fx, fy, tx, ty);
      kind_king:   ok = adx <= 1 && ady <= 1;
      default:     ok = 1'b0;
    endcase
    return ok;
  endfunction

  task automatic axi_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    s_awaddr  = addr;
    s_awvalid = 1'b1;
    s_wdata   = data;
    s_wstrb   = 4'hf;
    s_wvalid  = 1'b1;
    @(negedge clk);
    while (!s_awready) @(negedge clk);
    @(posedge clk);
    #1;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b1;
    @(negedge clk);
    while (!s_bvalid) @(negedge clk);
    resp = s_bresp;
    @(posedge clk);
    #1;
    s_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [addr_w-1:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    @(negedge clk);
    while (!s_arready) @(negedge clk);
    @(posedge clk);
    #1;
    s_arvalid = 1'b0;
    s_rready  = 1'b1;
    @(negedge clk);
    while (!s_rvalid) @(negedge clk);
    data = s_rdata;
    resp = s_rresp;
    @(posedge clk);
    #1;
    s_rready = 1'b0;
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Fail %0t: %s response %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic place(input int x, input int y, input piece_t p);
    logic [1:0] resp;
    axi_write(addr_w'(reg_board_off), board_word(x, y, p), resp);
    check_resp(resp, resp_okay, "board write");
    model[y * 8 + x] = p;
  endtask

  task automatic clear_board();
    for (int i = 0; i < board_squares; i++) begin
      place(i % 8, i / 8, piece_empty);
    end
  endtask

  task automatic wait_done(output logic [31:0] status);
    logic [1:0] resp;
    int         polls;
    polls = 0;
    axi_read(addr_w'(reg_status_off), status, resp);
    while ((status[0] || !status[1]) && polls < max_polls) begin
      axi_read(addr_w'(reg_status_off), status, resp);
      polls++;
    end
    if (status[0] || !status[1]) begin
      errors++;
      $display("move did not finish after %0d status polls", polls);
    end
  endtask

  task automatic check_status(input logic [31:0] status, input logic exp, input int fx,
                              input int fy, input int tx, input int ty);
    checks++;
    assert (status == {29'd0, exp, 1'b1, 1'b0}) else begin
      errors++;
      $display("Fail %0t: move (%0d,%0d)->(%0d,%0d) status %b, expected legal %0b",
               $time, fx, fy, tx, ty, status[2:0], exp);
    end
  endtask

  task automatic check_move(input int fx, input int fy, input int tx, input int ty);
    logic [1:0]  resp;
    logic [31:0] status;
    logic        exp;
    exp = ref_legal(fx, fy, tx, ty);
    axi_write(addr_w'(reg_move_off), move_word(fx, fy, tx, ty), resp);
    check_resp(resp, resp_okay, "move write");
    wait_done(status);
    check_status(status, exp, fx, fy, tx, ty);
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    logic        exp;
    logic [2:0]  kinds [4];
    int          fx, fy, tx, ty;
    errors    = 0;
    checks    = 0;
    reset     = 1'b1;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    void'($urandom(32'haa30));
    kinds     = '{kind_knight, kind_bishop, kind_queen, kind_king};
    for (int i = 0; i < board_squares; i++) model[i] = piece_empty;

    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    checks++;
    assert (!s_awready && !s_wready && !s_arready && !s_bvalid && !s_rvalid) else begin
      errors++;
      $display("Fail %0t: AXI outputs not idle after reset", $time);
    end
    // board clear sweep
    repeat (70) @(posedge clk);
    #1;

    axi_read(addr_w'(reg_status_off), data, resp);
    checks++;
    assert (data == 32'd0 && resp == resp_okay) else begin
      errors++;
      $display("Fail %0t: status after reset %h, expected 0", $time, data);
    end
    axi_read(addr_w'(8'h0c), data, resp);
    checks++;
    assert (data == 32'd0 && resp == resp_okay) else begin
      errors++;
      $display("Fail %0t: unmapped read returned %h", $time, data);
    end

    // rook on an open board and then with blockers
    place(0, 0, make_piece(1'b0, kind_rook));
    check_move(0, 0, 0, 7);
    check_move(0, 0, 7, 0);
    check_move(0, 0, 3, 3);
    place(0, 3, make_piece(1'b0, kind_pawn));
    check_move(0, 0, 0, 7);
    check_move(0, 0, 0, 3);
    place(0, 3, make_piece(1'b1, kind_pawn));
    check_move(0, 0, 0, 3);
    check_move(0, 0, 0, 7);

    // white pawn
    clear_board();
    place(4, 1, make_piece(1'b0, kind_pawn));
    check_move(4, 1, 4, 2);
    check_move(4, 1, 4, 3);
    check_move(4, 1, 4, 4);
    check_move(4, 1, 4, 0);
    check_move(4, 1, 5, 2);
    place(5, 2, make_piece(1'b1, kind_knight));
    check_move(4, 1, 5, 2);
    place(4, 2, make_piece(1'b1, kind_pawn));
    check_move(4, 1, 4, 3);
    check_move(4, 1, 4, 2);

    // black pawn moving toward lower ranks
    place(2, 6, make_piece(1'b1, kind_pawn));
    check_move(2, 6, 2, 5);
    check_move(2, 6, 2, 4);
    check_move(2, 6, 2, 7);
    place(1, 5, make_piece(1'b0, kind_bishop));
    check_move(2, 6, 1, 5);
    place(2, 5, make_piece(1'b0, kind_rook));
    check_move(2, 6, 2, 4);
    place(3, 4, make_piece(1'b1, kind_pawn));
    check_move(3, 4, 3, 2);
    check_move(3, 4, 3, 3);

    // writes during a long path walk are refused
    clear_board();
    place(7, 0, make_piece(1'b0, kind_rook));
    exp = ref_legal(7, 0, 7, 7);
    axi_write(addr_w'(reg_move_off), move_word(7, 0, 7, 7), resp);
    check_resp(resp, resp_okay, "move write");
    axi_write(addr_w'(reg_board_off), board_word(7, 4, make_piece(1'b1, kind_pawn)), resp);
    check_resp(resp, resp_slverr, "board write while busy");
    axi_write(addr_w'(reg_move_off), move_word(7, 0, 6, 1), resp);
    check_resp(resp, resp_slverr, "move write while busy");
    wait_done(data);
    check_status(data, exp, 7, 0, 7, 7);
    check_move(7, 0, 7, 7);

    // random board with random pieces on the source square
    for (int i = 0; i < board_squares; i++) begin
      if ($urandom % 2) begin
        place(i % 8, i / 8, make_piece(1'($urandom % 2), 3'(1 + $urandom % 6)));
      end else begin
        place(i % 8, i / 8, piece_empty);
      end
    end
    for (int m = 0; m < 200; m++) begin
      fx = $urandom % 8;
      fy = $urandom % 8;
      tx = $urandom % 8;
      ty = $urandom % 8;
      place(fx, fy, make_piece(1'($urandom % 2), kinds[$urandom % 4]));
      check_move(fx, fy, tx, ty);
    end

    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
chess_pkg.sv
board_ram.sv
step_geometry.sv
path_scanner.sv
move_controller.sv
axil_regs.sv
chess_checker_top.sv
tb_chess_checker.sv

//--- Bender.yml
package:
  name: chess_checker

sources:
  - chess_pkg.sv
  - board_ram.sv
  - step_geometry.sv
  - path_scanner.sv
  - move_controller.sv
  - axil_regs.sv
  - chess_checker_top.sv
  - target: test
    files:
      - tb_chess_checker.sv
